// File: files.f
verilog/route_pkg.sv
verilog/response_pkg.sv
verilog/response_queue.sv
verilog/delivery_tracker.sv
verilog/multicast_dispatch.sv
verilog/response_distributor.sv
tests/clock_gen.sv
tests/response_distributor_checker.sv
tests/tb_response_distributor.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the response distributor testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
  --top-module tb_response_distributor -f files.f > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_response_distributor +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tests/tb_response_distributor.sv
// Testbench for the response distributor
// Wishbone master, random receivers and per-receiver expected queues

`timescale 1ns/1ns
`default_nettype none

module tb_response_distributor
  import route_pkg::*, response_pkg::*;
();

  localparam int unsigned num_receivers = 4;
  localparam int unsigned queue_depth   = 8;
  // 24 routed, 4 dropped, then queue_depth + 1 under back-pressure
  localparam int unsigned num_writes    = 28 + queue_depth + 1;
  localparam int unsigned cycle_limit   = 40 * num_writes + 200;

  logic              ap_clk;
  logic              areset_control;
  logic              wb_cyc;
  logic              wb_stb;
  logic              wb_we;
  logic              wb_ack;
  response_payload_t wb_dat;
  response_payload_t out_payload;
  receiver_vec_t     out_valid;
  receiver_vec_t     out_ready  = '0;
  logic              ready_hold = 1'b0;
  logic [7:0]        next_tag   = '0;
  integer            seed       = 32'h6e9e;
  int unsigned       errors     = 0;
  int unsigned       acks       = 0;
  int unsigned       cycles     = 0;
  // Payloads each receiver is still owed, oldest first
  response_payload_t expected [num_receivers][$];

  clock_gen clock_gen_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control)
  );

  response_distributor #(
    .num_receivers (num_receivers),
    .queue_depth   (queue_depth)
  ) response_distributor_inst (.*);

  bind response_distributor response_distributor_checker #(
    .num_receivers (num_receivers)
  ) checker_inst (.*);

  function automatic int unsigned pending();
    int unsigned total;
    total = 0;
    for (int i = 0; i < num_receivers; i++) begin
      total += expected[i].size();
    end
    return total;
  endfunction

  // Strobe until ack or until max_cycles have passed
  // A strobe that is still held keeps its data
  task automatic send_response(input dest_mask_t dest, input int unsigned max_cycles,
                               output logic acked);
    int unsigned waited;
    waited = 0;
    acked  = 1'b0;
    if (!wb_stb) begin
      wb_dat = '{data: $random(seed), tag: next_tag, dest: dest};
      next_tag++;
    end
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    while (!acked && waited < max_cycles) begin
      @(negedge ap_clk);
      acked = wb_ack;
      waited++;
    end
    @(posedge ap_clk);
    #1;
    wb_cyc = !acked;
    wb_stb = !acked;
  endtask

  task automatic wait_drained();
    while (pending() != 0) @(negedge ap_clk);
    @(posedge ap_clk);
    #1;
  endtask

  // Random receivers that all stall while ready_hold is set
  always @(posedge ap_clk) begin
    #1;
    out_ready = ready_hold ? '0 : receiver_vec_t'($random(seed));
  end

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, %0d deliveries outstanding", cycles, pending());
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // Acked writes fill the expected queues and transfers drain them
  always @(negedge ap_clk) begin
    if (wb_ack) begin
      acks++;
      for (int i = 0; i < num_receivers; i++) begin
        if (wb_dat.dest[i]) expected[i].push_back(wb_dat);
      end
    end
    for (int i = 0; i < num_receivers; i++) begin
      if (out_valid[i] && out_ready[i]) begin
        assert (expected[i].size() != 0 && out_payload == expected[i][0]) else begin
          errors++;
          $display("FAILED %0t: receiver %0d got unexpected %h", $time, i, out_payload);
        end
        if (expected[i].size() != 0) void'(expected[i].pop_front());
      end
    end
  end

  initial begin
    logic        acked;
    int unsigned accepted;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b1;
    wb_dat   = '0;
    accepted = 0;
    @(negedge areset_control);
    repeat (2) @(posedge ap_clk);
    #1;
    // Unicast first and then a mix of unicast and multicast
    // Later masks also name receivers that are not present
    for (int k = 0; k < 24; k++) begin
      send_response(k < 8 ? dest_mask_t'(1 << (k % num_receivers))
                          : dest_mask_t'((k % 15 + 1) | ((k & 12) << 4)), 100, acked);
    end
    // Empty mask and masks above the present receivers
    for (int k = 0; k < 4; k++) begin
      send_response(dest_mask_t'(k == 0 ? 0 : 8'h08 << k), 100, acked);
    end
    // ----------------------------------------------
    // Back-pressure with every receiver stalled
    // ----------------------------------------------
    wait_drained();
    ready_hold = 1'b1;
    for (int k = 0; k <= queue_depth; k++) begin
      send_response(dest_mask_t'(k % 15 + 1), 20, acked);
      accepted += acked;
    end
    assert (accepted == queue_depth && !acked) else begin
      errors++;
      $display("FAILED %0t: %0d writes taken while stalled, expected %0d",
               $time, accepted, queue_depth);
    end
    ready_hold = 1'b0;
    send_response('0, 100, acked);
    wait_drained();
    repeat (5) @(posedge ap_clk);
    assert (acks == num_writes) else begin
      errors++;
      $display("FAILED %0t: only %0d of %0d writes were acknowledged",
               $time, acks, num_writes);
    end
    $display("Checks done: %0d testbench errors, %0d assertion failures", errors,
             response_distributor_inst.checker_inst.violations);
    if (errors == 0 && response_distributor_inst.checker_inst.violations == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule : tb_response_distributor

`default_nettype wire

// File: tests/response_distributor_checker.sv
// Concurrent assertions on the response distributor ports
// Wishbone ack shape, output stability and per-receiver delivery rules

`timescale 1ns/1ns
`default_nettype none

module response_distributor_checker
  import route_pkg::*, response_pkg::*;
#(
  parameter int unsigned num_receivers = 4
) (
  input logic              ap_clk,
  input logic              areset_control,
  input logic              wb_cyc,
  input logic              wb_stb,
  input logic              wb_ack,
  input receiver_vec_t     out_valid,
  input receiver_vec_t     out_ready,
  input response_payload_t out_payload
);

  int unsigned violations = 0;
  logic        stb_seen;

  task automatic note_violation(input string what);
    violations++;
    $error("%s", what);
  endtask

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      stb_seen <= 1'b0;
    end else if (wb_cyc && wb_stb) begin
      stb_seen <= 1'b1;
    end
  end

  // ----------------------------------------------
  // Bus side
  // ----------------------------------------------
  quiet_until_write: assert property (@(posedge ap_clk) disable iff (areset_control)
    !stb_seen |-> !wb_ack && out_valid == '0)
    else note_violation("ack or valid seen before the first write");

  ack_one_cycle: assert property (@(posedge ap_clk) disable iff (areset_control)
    wb_ack |=> !wb_ack)
    else note_violation("wb_ack high two cycles in a row");

  // ----------------------------------------------
  // Receiver side
  // ----------------------------------------------
  no_absent_valid: assert property (@(posedge ap_clk) disable iff (areset_control)
    (out_valid & ~present_mask(num_receivers)) == '0)
    else note_violation("valid raised for a receiver that is not present");

  for (genvar i = 0; i < num_receivers; i++) begin : g_receiver
    hold_until_taken: assert property (@(posedge ap_clk) disable iff (areset_control)
      out_valid[i] && !out_ready[i] |=> out_valid[i] && $stable(out_payload))
      else note_violation("valid or payload changed before the transfer");

    once_per_entry: assert property (@(posedge ap_clk) disable iff (areset_control)
      out_valid[i] && out_ready[i] |=> !out_valid[i])
      else note_violation("valid repeated right after a transfer");

    routed_only: assert property (@(posedge ap_clk) disable iff (areset_control)
      out_valid[i] |-> out_payload.dest[i])
      else note_violation("valid raised for a receiver outside the mask");
  end

endmodule : response_distributor_checker

`default_nettype wire

// File: tests/clock_gen.sv
// Free-running test clock and power-on reset

`timescale 1ns/1ns
`default_nettype none

module clock_gen #(
  parameter int unsigned period_ns    = 100,
  parameter int unsigned reset_cycles = 4
) (
  output logic ap_clk,
  output logic areset_control
);

  initial begin
    ap_clk = 1'b0;
    forever #(period_ns / 2) ap_clk = ~ap_clk;
  end

  // Reset held over reset_cycles rising edges
  initial begin
    areset_control = 1'b1;
    repeat (reset_cycles) @(posedge ap_clk);
    #1;
    areset_control = 1'b0;
  end

endmodule : clock_gen

`default_nettype wire

// File: verilog/response_distributor.sv
// Top level of the response distributor
// Queue, delivery tracker and multicast dispatch

`timescale 1ns/1ns
`default_nettype none

module response_distributor
  import route_pkg::*, response_pkg::*;
#(
  parameter int unsigned num_receivers = 4,
  parameter int unsigned queue_depth   = 8
) (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              wb_cyc,
  input  logic              wb_stb,
  input  logic              wb_we,
  input  response_payload_t wb_dat,
  output logic              wb_ack,
  input  receiver_vec_t     out_ready,
  output receiver_vec_t     out_valid,
  output response_payload_t out_payload
);

  // ----------------------------------------------
  // Internal wiring
  // ----------------------------------------------
  response_t     queue_head;
  logic          pop;
  receiver_vec_t taken;
  receiver_vec_t taken_now;

  response_queue #(
    .entry_t       (response_payload_t),
    .queue_depth   (queue_depth),
    .num_receivers (num_receivers)
  ) response_queue_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_dat         (wb_dat),
    .wb_ack         (wb_ack),
    .pop            (pop),
    .head_valid     (queue_head.valid),
    .head           (queue_head.payload)
  );

  delivery_tracker #(
    .num_receivers (num_receivers)
  ) delivery_tracker_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .taken_now      (taken_now),
    .pop            (pop),
    .taken          (taken)
  );

  multicast_dispatch #(
    .num_receivers (num_receivers)
  ) multicast_dispatch_inst (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .head_valid     (queue_head.valid),
    .head           (queue_head.payload),
    .taken          (taken),
    .out_ready      (out_ready),
    .pop            (pop),
    .taken_now      (taken_now),
    .out_valid      (out_valid),
    .out_payload    (out_payload)
  );

endmodule : response_distributor

`default_nettype wire

// File: verilog/multicast_dispatch.sv
// Offer of the head response to the receivers still owed it
// Pop once the last owed receiver has transferred
// Registered per-receiver valid and shared payload

`timescale 1ns/1ns
`default_nettype none

module multicast_dispatch
  import route_pkg::*, response_pkg::*;
#(
  parameter int unsigned num_receivers = 4
) (
  input  logic              ap_clk,
  input  logic              areset_control,
  input  logic              head_valid,
  input  response_payload_t head,
  input  receiver_vec_t     taken,
  input  receiver_vec_t     out_ready,
  output logic              pop,
  output receiver_vec_t     taken_now,
  output receiver_vec_t     out_valid,
  output response_payload_t out_payload
);

  receiver_vec_t present;
  receiver_vec_t owed;
  receiver_vec_t out_valid_next;

  // ----------------------------------------------
  // Receivers still owed the head
  // ----------------------------------------------
  assign present = present_mask(num_receivers);
  assign owed    = head_valid ? (head.dest & present & ~taken) : '0;

  assign taken_now = out_valid & out_ready;

  // A receiver that transfers now drops its valid on the next edge
  assign out_valid_next = owed & ~taken_now;

  // Head leaves when nobody is left waiting on it
  assign pop = head_valid & ~(|out_valid_next);

  // ----------------------------------------------
  // Output registers
  // ----------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      out_valid <= '0;
    end else begin
      out_valid <= out_valid_next;
    end
  end

  // Head only changes after a pop, when all valids are low
  always_ff @(posedge ap_clk) begin
    out_payload <= head;
  end

endmodule : multicast_dispatch

`default_nettype wire

// File: verilog/delivery_tracker.sv
// Record of the receivers that have taken the head response
// Cleared when the head leaves the queue

`timescale 1ns/1ns
`default_nettype none

module delivery_tracker
  import route_pkg::*;
#(
  parameter int unsigned num_receivers = 4
) (
  input  logic          ap_clk,
  input  logic          areset_control,
  input  receiver_vec_t taken_now,
  input  logic          pop,
  output receiver_vec_t taken
);

  // ----------------------------------------------
  // Accumulated transfers for the current head
  // ----------------------------------------------
  receiver_vec_t present;
  receiver_vec_t taken_next;

  assign present = present_mask(num_receivers);

  // Receivers may accept in different cycles, so keep a running OR
  always_comb begin
    if (pop) begin
      taken_next = '0;
    end else begin
      taken_next = taken | (taken_now & present);
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      taken <= '0;
    end else begin
      taken <= taken_next;
    end
  end

endmodule : delivery_tracker

`default_nettype wire

// File: verilog/response_queue.sv
// Wishbone classic write intake with registered ack
// Drop of responses whose mask names no present receiver
// First-word-fall-through response FIFO

`timescale 1ns/1ns
`default_nettype none

module response_queue
  import route_pkg::*, response_pkg::*;
#(
  parameter type         entry_t       = response_payload_t,
  parameter int unsigned queue_depth   = 8,
  parameter int unsigned num_receivers = 4
) (
  input  logic   ap_clk,
  input  logic   areset_control,
  input  logic   wb_cyc,
  input  logic   wb_stb,
  input  logic   wb_we,
  input  entry_t wb_dat,
  output logic   wb_ack,
  input  logic   pop,
  output logic   head_valid,
  output entry_t head
);

  localparam int unsigned addr_w = $clog2(queue_depth);
  localparam int unsigned cnt_w  = addr_w + 1;

  // ----------------------------------------------
  // Intake register stage
  // ----------------------------------------------
  entry_t           in_data;
  logic             in_valid;
  logic             accept;
  logic             routable;
  logic             has_space;
  logic [cnt_w:0]   fill;

  // FIFO state
  entry_t            mem [queue_depth];
  logic [addr_w-1:0] wr_ptr;
  logic [addr_w-1:0] rd_ptr;
  logic [cnt_w-1:0]  count;
  logic              pop_ok;

  // Stored entries plus the one waiting in the intake register
  assign fill      = {1'b0, count} + {{cnt_w{1'b0}}, in_valid};
  assign has_space = fill < (cnt_w + 1)'(queue_depth);
  assign routable  = |(wb_dat.dest & present_mask(num_receivers));

  // No ack in the cycle right after an ack
  assign accept = wb_cyc & wb_stb & ~wb_ack & has_space;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wb_ack   <= 1'b0;
      in_valid <= 1'b0;
    end else begin
      wb_ack   <= accept;
      in_valid <= accept & wb_we & routable;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (accept) begin
      in_data <= wb_dat;
    end
  end

  // ----------------------------------------------
  // Response FIFO
  // ----------------------------------------------
  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign pop_ok     = pop & head_valid;

  always_ff @(posedge ap_clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (in_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({in_valid, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule : response_queue

`default_nettype wire

// File: verilog/response_pkg.sv
// Memory response payload as carried through the distributor
// Valid-tagged response used between the queue and the dispatch

`default_nettype none

package response_pkg;

  import route_pkg::*;

  // ----------------------------------------------
  // Response payload, 48 bits
  // ----------------------------------------------
  typedef struct packed {
    // Read data word from memory
    logic [31:0] data;
    // Tag of the requester that issued the read
    logic [7:0]  tag;
    // Receivers that get this response
    dest_mask_t  dest;
  } response_payload_t;

  // ----------------------------------------------
  // Payload with its valid flag
  // ----------------------------------------------
  typedef struct packed {
    logic              valid;
    response_payload_t payload;
  } response_t;

endpackage : response_pkg

`default_nettype wire

// File: verilog/route_pkg.sv
// Receiver count limit for the response distributor
// Destination mask and per-receiver flag vector types
// Helper that masks off receivers that are not present

`default_nettype none

package route_pkg;

  // ----------------------------------------------
  // Receiver limits
  // ----------------------------------------------
  localparam int unsigned max_receivers = 8;

  // Bit i names receiver i
  typedef logic [max_receivers-1:0] dest_mask_t;

  // Per-receiver valid, ready and taken flags
  typedef logic [max_receivers-1:0] receiver_vec_t;

  // Ones for every receiver below num_receivers
  function automatic dest_mask_t present_mask(input int unsigned num_receivers);
    dest_mask_t mask;
    mask = '0;
    for (int unsigned i = 0; i < max_receivers; i++) begin
      mask[i] = (i < num_receivers);
    end
    return mask;
  endfunction

endpackage : route_pkg

`default_nettype wire
